//--- sim/pr_region_cases.txt
# W address data byteenable | R address expected | S next persona | L count of LFSR writes
# F next persona, then address data byteenable of a write raised while frozen
W 0 11223344 f
W 1 a5a5a5a5 f
R 0 11223344
W 0 deadbeef 3
R 0 1122beef
W 1 00ff0000 4
R 1 a5ffa5a5
W f 87654321 c
R f 87650000
S 1
R 0 00000000
W 0 00000010 f
W 0 ffffffff 1
W 1 f0f0f0f0 f
W 1 0000ff00 2
R 0 0000010f
R 1 f0f00ff0
R 2 00000004
R 3 00000000
W 3 00000000 f
R 0 00000000
R 1 00000000
R 2 00000000
F 0 5 cafef00d f
R 0 00000000
R f 00000000
R 5 cafef00d
L 8

//--- files.f
logic/pr_ctrl_pkg.sv
logic/pr_bus_pkg.sv
logic/pr_freeze_ctrl.sv
logic/pr_persona_mux.sv
logic/persona_scratch.sv
logic/persona_checksum.sv
logic/pr_region_wrapper.sv
sim/pr_region_sva.sv
sim/pr_region_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := pr_region_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/pr_region_tb.sv
// Testbench for the PR region; run it from the project root so that the cases file is found
`timescale 1ns/10ps
`default_nettype none

module pr_region_tb;

  import pr_bus_pkg::*;
  import pr_ctrl_pkg::*;

  localparam int reset_cycles = 16;

  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] arg0;
    logic [31:0] arg1;
    logic [31:0] arg2;
    logic [31:0] arg3;
  } case_t;

  logic        clk = 1'b0;
  logic        reset;
  avmm_req_t   host_req;
  avmm_rsp_t   host_rsp;
  logic        stop_req;
  logic        start_req;
  persona_id_t next_persona;
  logic        stop_ack;
  logic        start_ack;
  logic        freeze;
  bit          loaded;

  case_t       cases[$];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic [15:0] lfsr = 16'd94;

  // Reference model of both personas
  persona_id_t active_m;
  logic [31:0] scratch_m [16];
  logic [31:0] sum_m;
  logic [31:0] xor_m;
  logic [31:0] count_m;

  pr_region_wrapper UUT (
    .pr_region_clk (clk),
    .reset         (reset),
    .host_req      (host_req),
    .stop_req      (stop_req),
    .start_req     (start_req),
    .next_persona  (next_persona),
    .host_rsp      (host_rsp),
    .stop_ack      (stop_ack),
    .start_ack     (start_ack),
    .freeze        (freeze)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Steps the Galois LFSR once per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] be);
    logic [31:0] v;
    v = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        v[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return v;
  endfunction

  task automatic clear_model(input persona_id_t p);
    if (p == scratch_persona) begin
      foreach (scratch_m[i]) begin
        scratch_m[i] = '0;
      end
    end else begin
      sum_m   = '0;
      xor_m   = '0;
      count_m = '0;
    end
  endtask

  task automatic model_write(input logic [3:0] addr, input logic [31:0] data, input logic [3:0] be);
    if (active_m == scratch_persona) begin
      scratch_m[addr] = merge_lanes(scratch_m[addr], data, be);
    end else begin
      case (checksum_reg_e'(addr))
        reg_sum: begin
          sum_m   = sum_m + merge_lanes('0, data, be);
          count_m = count_m + 32'd1;
        end
        reg_xor: begin
          xor_m   = xor_m ^ merge_lanes('0, data, be);
          count_m = count_m + 32'd1;
        end
        reg_clear: clear_model(checksum_persona);
        default: begin
        end
      endcase
    end
  endtask

  function automatic logic [31:0] model_read(input logic [3:0] addr);
    logic [31:0] v;
    v = '0;
    if (active_m == scratch_persona) begin
      v = scratch_m[addr];
    end else begin
      case (checksum_reg_e'(addr))
        reg_sum:   v = sum_m;
        reg_xor:   v = xor_m;
        reg_count: v = count_m;
        default:   v = '0;
      endcase
    end
    return v;
  endfunction

  // One host access; ack_seen is start_ack in the cycle the request gets through
  task automatic bus_access(input logic do_read, input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] be, output logic [31:0] rdata, output int stalls,
                            output logic ack_seen);
    avmm_req_t req;
    req            = '0;
    req.read       = do_read;
    req.write      = !do_read;
    req.address    = addr;
    req.writedata  = data;
    req.byteenable = be;
    stalls         = 0;
    @(negedge clk);
    host_req = req;
    while (host_rsp.waitrequest) begin
      stalls++;
      @(negedge clk);
    end
    ack_seen = start_ack;
    @(negedge clk);
    host_req = '0;
    rdata    = host_rsp.readdata;
    check(32'(host_rsp.readdatavalid), 32'(do_read), "readdatavalid after access");
  endtask

  // Four-phase stop, then four-phase start with the new persona number
  task automatic swap_persona(input persona_id_t p);
    @(negedge clk);
    stop_req = 1'b1;
    while (!stop_ack) @(negedge clk);
    check(32'(freeze), 32'd1, "freeze high at stop_ack");
    stop_req = 1'b0;
    @(negedge clk);
    check(32'(stop_ack), 32'd0, "stop_ack low one cycle after stop_req drops");
    check(32'(freeze), 32'd1, "freeze high before start_req");
    next_persona = p;
    start_req    = 1'b1;
    while (!start_ack) @(negedge clk);
    check(32'(freeze), 32'd0, "freeze low at start_ack");
    start_req = 1'b0;
    @(negedge clk);
    check(32'(start_ack), 32'd0, "start_ack low one cycle after start_req drops");
    active_m = p;
    clear_model(p);
  endtask

  task automatic random_scratch(input int n);
    logic [3:0]  addr;
    logic [3:0]  be;
    logic [31:0] data;
    logic [31:0] rdata;
    int          stalls;
    logic        ack_seen;
    for (int i = 0; i < n; i++) begin
      addr = 4'(random_bits(4));
      be   = 4'(random_bits(4));
      data = random_bits(32);
      bus_access(1'b0, addr, data, be, rdata, stalls, ack_seen);
      model_write(addr, data, be);
    end
    for (int a = 0; a < 16; a++) begin
      bus_access(1'b1, 4'(a), '0, '0, rdata, stalls, ack_seen);
      check(rdata, model_read(4'(a)), $sformatf("read back of random word %0d", a));
    end
  endtask

  task automatic run_case(input case_t c);
    logic [31:0] rdata;
    logic [31:0] expected;
    int          stalls;
    logic        ack_seen;
    case (c.op)
      "W": begin
        bus_access(1'b0, 4'(c.arg0), c.arg1, 4'(c.arg2), rdata, stalls, ack_seen);
        model_write(4'(c.arg0), c.arg1, 4'(c.arg2));
      end
      "R": begin
        expected = model_read(4'(c.arg0));
        bus_access(1'b1, 4'(c.arg0), '0, '0, rdata, stalls, ack_seen);
        check(rdata, expected, $sformatf("read of address %0h", c.arg0));
        check(c.arg1, expected, "expected value in cases file");
      end
      "S": swap_persona(persona_id_t'(c.arg0[0]));
      "F": begin
        // The write is raised once the region is frozen and must wait out the swap
        fork
          swap_persona(persona_id_t'(c.arg0[0]));
          begin
            while (!freeze) @(negedge clk);
            bus_access(1'b0, 4'(c.arg1), c.arg2, 4'(c.arg3), rdata, stalls, ack_seen);
          end
        join
        check(32'(stalls != 0), 32'd1, "host write held off while frozen");
        check(32'(ack_seen), 32'd1, "host write accepted after start_ack");
        model_write(4'(c.arg1), c.arg2, 4'(c.arg3));
      end
      "L": random_scratch(int'(c.arg0));
      default: begin
        errors++;
        $display("Unknown operation '%c' in the cases file", c.op);
      end
    endcase
  endtask

  task automatic load_cases(output bit ok);
    int          fd;
    int          n;
    string       line;
    case_t       c;
    logic [31:0] a [4];
    fd = $fopen("sim/pr_region_cases.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          a = '{default: '0};
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a[0], a[1], a[2], a[3]);
          c = '{op: line.getc(0), arg0: a[0], arg1: a[1], arg2: a[2], arg3: a[3]};
          cases.push_back(c);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    reset        = 1'b1;
    host_req     = '0;
    stop_req     = 1'b0;
    start_req    = 1'b0;
    next_persona = scratch_persona;
    active_m     = reset_persona;
    clear_model(scratch_persona);
    clear_model(checksum_persona);
    load_cases(loaded);
    if (!loaded) begin
      $display("Cannot open the cases file sim/pr_region_cases.txt");
      $display("Simulation finished: FAIL");
    end else begin
      cycle_limit = cases.size() * 20 + reset_cycles;
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      foreach (cases[i]) begin
        run_case(cases[i]);
      end
      @(negedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/pr_region_sva.sv
// Bus and handshake assertions bound into the PR region; they assume a read latency of one cycle
`timescale 1ns/10ps
`default_nettype none

module pr_region_sva (
  input wire                      clk,
  input wire                      reset,
  input pr_bus_pkg::avmm_req_t    host_req,
  input pr_bus_pkg::avmm_rsp_t    host_rsp,
  input wire                      stop_req,
  input wire                      stop_ack,
  input wire                      start_req,
  input wire                      start_ack,
  input wire                      freeze,
  input pr_ctrl_pkg::persona_id_t active_persona,
  input wire                      persona_reset
);

  logic read_accepted;

  assign read_accepted = host_req.read && !host_rsp.waitrequest;

  frozen_holds_host: assert property (@(posedge clk) disable iff (reset)
    freeze |-> host_rsp.waitrequest)
    else $error("waitrequest low while the region is frozen");

  // The ack is registered, so its req was high on the edge that raised it
  stop_ack_after_req: assert property (@(posedge clk) disable iff (reset)
    $rose(stop_ack) |-> $past(stop_req))
    else $error("stop_ack rose without stop_req");

  start_ack_after_req: assert property (@(posedge clk) disable iff (reset)
    $rose(start_ack) |-> $past(start_req))
    else $error("start_ack rose without start_req");

  read_returns: assert property (@(posedge clk) disable iff (reset)
    read_accepted |=> host_rsp.readdatavalid)
    else $error("accepted read gave no readdatavalid one cycle later");

  no_stray_valid: assert property (@(posedge clk) disable iff (reset)
    host_rsp.readdatavalid |-> $past(read_accepted))
    else $error("readdatavalid without an accepted read");

  // persona_reset is high exactly in the starting state
  persona_loads_on_start: assert property (@(posedge clk) disable iff (reset)
    $changed(active_persona) |-> persona_reset)
    else $error("active persona changed outside the starting state");

endmodule

bind pr_region_wrapper pr_region_sva u_sva (
  .clk            (pr_region_clk),
  .reset          (reset),
  .host_req       (host_req),
  .host_rsp       (host_rsp),
  .stop_req       (stop_req),
  .stop_ack       (stop_ack),
  .start_req      (start_req),
  .start_ack      (start_ack),
  .freeze         (freeze),
  .active_persona (active_persona),
  .persona_reset  (persona_reset)
);

`default_nettype wire

//--- logic/pr_region_wrapper.sv
// PR region top: both personas stay instantiated, only the active one is routed to the host
`timescale 1ns/10ps
`default_nettype none

module pr_region_wrapper (
  input  wire                      pr_region_clk,
  input  wire                      reset,
  input  pr_bus_pkg::avmm_req_t    host_req,
  input  wire                      stop_req,
  input  wire                      start_req,
  input  pr_ctrl_pkg::persona_id_t next_persona,
  output pr_bus_pkg::avmm_rsp_t    host_rsp,
  output logic                     stop_ack,
  output logic                     start_ack,
  output logic                     freeze
);

  import pr_bus_pkg::*;
  import pr_ctrl_pkg::*;

  persona_id_t                   active_persona;
  logic                          persona_reset;
  logic [num_persona-1:0]        persona_rst;
  avmm_req_t [num_persona-1:0]   persona_req;
  avmm_rsp_t [num_persona-1:0]   persona_rsp;

  pr_freeze_ctrl u_freeze_ctrl (
    .pr_region_clk  (pr_region_clk),
    .reset          (reset),
    .stop_req       (stop_req),
    .start_req      (start_req),
    .next_persona   (next_persona),
    .stop_ack       (stop_ack),
    .start_ack      (start_ack),
    .freeze         (freeze),
    .active_persona (active_persona),
    .persona_reset  (persona_reset)
  );

  // Activation reset only hits the persona that is being brought in
  always_comb begin
    for (int i = 0; i < num_persona; i++) begin
      persona_rst[i] = reset | (persona_reset && (active_persona == persona_id_t'(i)));
    end
  end

  pr_persona_mux u_mux (
    .host_req       (host_req),
    .freeze         (freeze),
    .active_persona (active_persona),
    .persona_rsp    (persona_rsp),
    .host_rsp       (host_rsp),
    .persona_req    (persona_req)
  );

  persona_scratch u_scratch (
    .pr_region_clk (pr_region_clk),
    .reset         (persona_rst[scratch_persona]),
    .req           (persona_req[scratch_persona]),
    .rsp           (persona_rsp[scratch_persona])
  );

  persona_checksum u_checksum (
    .pr_region_clk (pr_region_clk),
    .reset         (persona_rst[checksum_persona]),
    .req           (persona_req[checksum_persona]),
    .rsp           (persona_rsp[checksum_persona])
  );

endmodule

`default_nettype wire

//--- logic/persona_checksum.sv
// Persona 1 keeps a sum, XOR and write count over masked data; addresses above clear read as zero
`timescale 1ns/10ps
`default_nettype none

module persona_checksum (
  input  wire                   pr_region_clk,
  input  wire                   reset,
  input  pr_bus_pkg::avmm_req_t req,
  output pr_bus_pkg::avmm_rsp_t rsp
);

  import pr_bus_pkg::*;

  checksum_reg_e         reg_addr;
  logic [data_width-1:0] masked_data;
  logic [data_width-1:0] sum_q;
  logic [data_width-1:0] xor_q;
  logic [data_width-1:0] count_q;
  logic [data_width-1:0] rdata_q;
  logic                  rdv_q;

  assign reg_addr    = checksum_reg_e'(req.address);
  assign masked_data = req.writedata & byte_mask(req.byteenable);

  // The sum wraps modulo 2^32, and count only moves on sum and xor writes
  always_ff @(posedge pr_region_clk) begin
    if (reset) begin
      sum_q   <= '0;
      xor_q   <= '0;
      count_q <= '0;
    end else if (req.write) begin
      case (reg_addr)
        reg_sum: begin
          sum_q   <= sum_q + masked_data;
          count_q <= count_q + 32'd1;
        end
        reg_xor: begin
          xor_q   <= xor_q ^ masked_data;
          count_q <= count_q + 32'd1;
        end
        reg_clear: begin
          sum_q   <= '0;
          xor_q   <= '0;
          count_q <= '0;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge pr_region_clk) begin
    if (reset) begin
      rdv_q <= 1'b0;
    end else begin
      rdv_q <= req.read;
    end
  end

  always_ff @(posedge pr_region_clk) begin
    if (req.read) begin
      case (reg_addr)
        reg_sum:   rdata_q <= sum_q;
        reg_xor:   rdata_q <= xor_q;
        reg_count: rdata_q <= count_q;
        default:   rdata_q <= '0;
      endcase
    end
  end

  assign rsp = '{waitrequest: 1'b0, readdatavalid: rdv_q, readdata: rdata_q};

endmodule

`default_nettype wire

//--- logic/persona_scratch.sv
// Persona 0: sixteen-word scratch file, cleared by reset, never stalls the host
`timescale 1ns/10ps
`default_nettype none

module persona_scratch (
  input  wire                   pr_region_clk,
  input  wire                   reset,
  input  pr_bus_pkg::avmm_req_t req,
  output pr_bus_pkg::avmm_rsp_t rsp
);

  import pr_bus_pkg::*;

  logic [data_width-1:0] mem [scratch_words];
  logic [data_width-1:0] wmask;
  logic [data_width-1:0] rdata_q;
  logic                  rdv_q;

  assign wmask = byte_mask(req.byteenable);

  // Byte lanes outside byteenable keep their old contents
  always_ff @(posedge pr_region_clk) begin
    if (reset) begin
      for (int i = 0; i < scratch_words; i++) begin
        mem[i] <= '0;
      end
    end else if (req.write) begin
      mem[req.address] <= (mem[req.address] & ~wmask) | (req.writedata & wmask);
    end
  end

  always_ff @(posedge pr_region_clk) begin
    if (reset) begin
      rdv_q <= 1'b0;
    end else begin
      rdv_q <= req.read;
    end
  end

  always_ff @(posedge pr_region_clk) begin
    if (req.read) begin
      rdata_q <= mem[req.address];
    end
  end

  assign rsp = '{waitrequest: 1'b0, readdatavalid: rdv_q, readdata: rdata_q};

endmodule

`default_nettype wire

//--- logic/pr_persona_mux.sv
// Host routing into the persona slot; purely combinational, so it adds no latency to the bus
`timescale 1ns/10ps
`default_nettype none

module pr_persona_mux (
  input  pr_bus_pkg::avmm_req_t                                host_req,
  input  wire                                                  freeze,
  input  pr_ctrl_pkg::persona_id_t                             active_persona,
  input  pr_bus_pkg::avmm_rsp_t [pr_ctrl_pkg::num_persona-1:0] persona_rsp,
  output pr_bus_pkg::avmm_rsp_t                                host_rsp,
  output pr_bus_pkg::avmm_req_t [pr_ctrl_pkg::num_persona-1:0] persona_req
);

  import pr_bus_pkg::*;
  import pr_ctrl_pkg::*;

  avmm_rsp_t sel_rsp;

  // Only the active persona is driven, and nothing gets through while frozen
  always_comb begin
    for (int i = 0; i < num_persona; i++) begin
      persona_req[i] = '0;
    end
    if (!freeze) begin
      persona_req[active_persona] = host_req;
    end
  end

  assign sel_rsp = persona_rsp[active_persona];

  // Frozen region holds the host off and masks read data
  // A read accepted on the freezing edge still completes with its data
  always_comb begin
    host_rsp = sel_rsp;
    if (freeze) begin
      host_rsp.waitrequest = 1'b1;
      if (!sel_rsp.readdatavalid) begin
        host_rsp.readdata = '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/pr_freeze_ctrl.sv
// Stop/start handshake FSM; the PR controller must hold each req until its ack rises
`timescale 1ns/10ps
`default_nettype none

module pr_freeze_ctrl (
  input  wire                      pr_region_clk,
  input  wire                      reset,
  input  wire                      stop_req,
  input  wire                      start_req,
  input  pr_ctrl_pkg::persona_id_t next_persona,
  output logic                     stop_ack,
  output logic                     start_ack,
  output logic                     freeze,
  output pr_ctrl_pkg::persona_id_t active_persona,
  output logic                     persona_reset
);

  import pr_ctrl_pkg::*;

  pr_state_e   state_q;
  persona_id_t active_q;
  logic        stop_ack_q;
  logic        start_ack_q;

  always_ff @(posedge pr_region_clk) begin
    if (reset) begin
      state_q     <= st_running;
      active_q    <= reset_persona;
      stop_ack_q  <= 1'b0;
      start_ack_q <= 1'b0;
    end else begin
      case (state_q)
        st_running: begin
          // Ack of the last start drops one cycle after its req
          start_ack_q <= start_ack_q & start_req;
          // A new stop waits until the previous start handshake has closed
          if (stop_req && !start_ack_q) begin
            state_q <= st_stopping;
          end
        end
        st_stopping: begin
          // Any read accepted just before the freeze returns in this cycle
          state_q    <= st_frozen;
          stop_ack_q <= 1'b1;
        end
        st_frozen: begin
          stop_ack_q <= stop_ack_q & stop_req;
          if (start_req && !stop_ack_q) begin
            state_q  <= st_starting;
            active_q <= next_persona;
          end
        end
        st_starting: begin
          state_q     <= st_running;
          start_ack_q <= 1'b1;
        end
        default: begin
          state_q <= st_running;
        end
      endcase
    end
  end

  // The region is frozen from the edge after stop_req up to the edge that raises start_ack
  assign freeze = (state_q != st_running);

  // The new persona sees its local reset during the single starting cycle
  assign persona_reset = (state_q == st_starting);

  assign active_persona = active_q;
  assign stop_ack       = stop_ack_q;
  assign start_ack      = start_ack_q;

endmodule

`default_nettype wire

//--- logic/pr_bus_pkg.sv
// Host bus definitions: single-beat 32-bit word access, no bursts, read latency of one cycle
`default_nettype none

package pr_bus_pkg;

  // Word address and data widths of the host slave bus
  localparam int addr_width = 4;
  localparam int data_width = 32;
  localparam int byte_lanes = data_width / 8;

  // Number of words in the scratch persona
  localparam int scratch_words = 2 ** addr_width;

  typedef struct packed {
    logic                  read;
    logic                  write;
    logic [addr_width-1:0] address;
    logic [data_width-1:0] writedata;
    logic [byte_lanes-1:0] byteenable;
  } avmm_req_t;

  typedef struct packed {
    logic                  waitrequest;
    logic                  readdatavalid;
    logic [data_width-1:0] readdata;
  } avmm_rsp_t;

  // Register map of the checksum persona
  typedef enum logic [addr_width-1:0] {
    reg_sum   = 4'd0,
    reg_xor   = 4'd1,
    reg_count = 4'd2,
    reg_clear = 4'd3
  } checksum_reg_e;

  // Expands byteenable into a bit mask over the data word
  function automatic logic [data_width-1:0] byte_mask(input logic [byte_lanes-1:0] be);
    logic [data_width-1:0] mask;
    for (int b = 0; b < byte_lanes; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

//--- logic/pr_ctrl_pkg.sv
// PR controller definitions: two personas only, and persona ids must stay below num_persona
`default_nettype none

package pr_ctrl_pkg;

  // Number of personas that share the region slot
  localparam int num_persona = 2;

  // Width of a persona number
  localparam int persona_width = $clog2(num_persona);

  typedef logic [persona_width-1:0] persona_id_t;

  // Persona numbering inside the slot
  localparam persona_id_t scratch_persona  = 1'b0;
  localparam persona_id_t checksum_persona = 1'b1;

  // The persona that is active straight out of reset
  localparam persona_id_t reset_persona = scratch_persona;

  // Stop/start handshake walk of the freeze controller
  // Stopping is the one cycle that lets an in-flight read return before stop_ack
  typedef enum logic [1:0] {
    st_running  = 2'd0,
    st_stopping = 2'd1,
    st_frozen   = 2'd2,
    st_starting = 2'd3
  } pr_state_e;

endpackage

`default_nettype wire
